/* common/alu_ops_pkg.sv */
package alu_ops_pkg;

    // ------------------------------
    // Field widths
    // ------------------------------
    typedef logic [31:0] word_t;
    typedef logic [7:0]  route_t;
    typedef logic [15:0] seq_id_t;
    typedef logic [3:0]  hops_t;

    // Last packet of a sequence is marked DONE
    typedef enum logic {
        SEQ_RUNNING = 1'b0,
        SEQ_DONE    = 1'b1
    } seq_state_e;

    typedef enum logic [2:0] {
        ALU_NOP = 3'd0,
        ALU_ADD = 3'd1,
        ALU_SUB = 3'd2,
        ALU_MUL = 3'd3,
        ALU_ACC = 3'd4
    } alu_op_e;

    typedef enum logic [2:0] {
        SETUP_RESET      = 3'd0,
        SETUP_IDLE       = 3'd1,
        SETUP_WAIT_START = 3'd2,
        SETUP_REQUEST    = 3'd3,
        SETUP_WAIT_CONFIG = 3'd4,
        SETUP_BUSY       = 3'd5,
        SETUP_PAUSE      = 3'd6
    } setup_state_e;

    // ------------------------------
    // Engine sizing
    // ------------------------------
    localparam int FIFO_DEPTH    = 16;
    // Leaves room for the packets still in flight after pops stop
    localparam int PROG_THRESH   = 8;
    localparam int KERNEL_STAGES = 2;

    // Packed FIFO words
    localparam int IN_PKT_W  = 2 * $bits(word_t) + $bits(route_t) + $bits(seq_state_e)
                             + $bits(seq_id_t) + $bits(hops_t);
    localparam int OUT_PKT_W = $bits(word_t) + 2 * $bits(route_t) + $bits(seq_state_e)
                             + $bits(seq_id_t) + $bits(hops_t);

endpackage : alu_ops_pkg

/* hdl/sync_fifo.sv */
`timescale 1ns/100ps

module sync_fifo #(
    parameter int WIDTH  = $bits(alu_ops_pkg::word_t),
    parameter int DEPTH  = alu_ops_pkg::FIFO_DEPTH,
    parameter int THRESH = alu_ops_pkg::PROG_THRESH
) (
    input  logic             ap_clk,
    input  logic             areset_generator,
    input  logic             wr_en,
    input  logic [WIDTH-1:0] din,
    input  logic             rd_en,
    output logic [WIDTH-1:0] dout,
    output logic             rd_valid,
    output logic             full,
    output logic             empty,
    output logic             prog_full
);

    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    logic [WIDTH-1:0] mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             wr_ok;
    logic             rd_ok;

    assign wr_ok     = wr_en & ~full;
    assign rd_ok     = rd_en & ~empty;
    assign full      = (count == CNT_W'(DEPTH));
    assign empty     = (count == '0);
    assign prog_full = (count >= CNT_W'(THRESH));

    // ------------------------------
    // Pointers and fill level
    // ------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            rd_valid <= 1'b0;
        end else begin
            if (wr_ok) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (rd_ok) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count    <= count + CNT_W'(wr_ok) - CNT_W'(rd_ok);
            rd_valid <= rd_ok;
        end
    end

    // Storage and registered read port
    always_ff @(posedge ap_clk) begin
        if (wr_ok) begin
            mem[wr_ptr] <= din;
        end
        if (rd_ok) begin
            dout <= mem[rd_ptr];
        end
    end

    // Callers must respect the flags
    assert property (@(posedge ap_clk) disable iff (areset_generator) wr_en |-> !full)
        else $error("sync_fifo write while full");
    assert property (@(posedge ap_clk) disable iff (areset_generator) rd_en |-> !empty)
        else $error("sync_fifo read while empty");

endmodule : sync_fifo

/* alu_ops/alu_ops_setup_fsm.sv */
`timescale 1ns/100ps

module alu_ops_setup_fsm (
    input  logic                  ap_clk,
    input  logic                  areset_generator,
    input  logic                  config_start,
    input  logic                  config_valid,
    input  alu_ops_pkg::alu_op_e  config_op,
    input  alu_ops_pkg::route_t   config_dest,
    input  logic                  out_prog_full,
    output logic                  configure_memory_setup,
    output logic                  run_enable,
    output alu_ops_pkg::alu_op_e  active_op,
    output alu_ops_pkg::route_t   active_dest,
    output logic                  running
);

    import alu_ops_pkg::*;

    setup_state_e state;
    setup_state_e next_state;

    // ------------------------------
    // State register
    // ------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            state <= SETUP_RESET;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            SETUP_RESET: begin
                next_state = SETUP_IDLE;
            end
            SETUP_IDLE: begin
                next_state = SETUP_WAIT_START;
            end
            SETUP_WAIT_START: begin
                if (config_start) begin
                    next_state = SETUP_REQUEST;
                end
            end
            SETUP_REQUEST: begin
                next_state = SETUP_WAIT_CONFIG;
            end
            SETUP_WAIT_CONFIG: begin
                if (config_valid) begin
                    next_state = SETUP_BUSY;
                end
            end
            SETUP_BUSY: begin
                if (out_prog_full) begin
                    next_state = SETUP_PAUSE;
                end
            end
            SETUP_PAUSE: begin
                if (!out_prog_full) begin
                    next_state = SETUP_BUSY;
                end
            end
            default: begin
                next_state = SETUP_RESET;
            end
        endcase
    end

    // ------------------------------
    // Request pulse and config latch
    // ------------------------------
    // REQUEST lasts one cycle, so the pulse does too
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            configure_memory_setup <= 1'b0;
            active_op              <= ALU_NOP;
        end else begin
            configure_memory_setup <= (state == SETUP_REQUEST);
            if (state == SETUP_WAIT_CONFIG && config_valid) begin
                active_op <= config_op;
            end
        end
    end

    always_ff @(posedge ap_clk) begin
        if (state == SETUP_WAIT_CONFIG && config_valid) begin
            active_dest <= config_dest;
        end
    end

    assign run_enable = (state == SETUP_BUSY);
    assign running    = (state == SETUP_BUSY) || (state == SETUP_PAUSE);

    assert property (@(posedge ap_clk) disable iff (areset_generator)
        state inside {SETUP_RESET, SETUP_IDLE, SETUP_WAIT_START, SETUP_REQUEST,
                      SETUP_WAIT_CONFIG, SETUP_BUSY, SETUP_PAUSE})
        else $error("setup FSM in illegal state");

endmodule : alu_ops_setup_fsm

/* alu_ops/alu_ops_kernel.sv */
`timescale 1ns/100ps

module alu_ops_kernel (
    input  logic                    ap_clk,
    input  logic                    areset_generator,
    input  alu_ops_pkg::alu_op_e    alu_op,
    input  logic                    data_valid,
    input  alu_ops_pkg::word_t      op_a,
    input  alu_ops_pkg::word_t      op_b,
    input  alu_ops_pkg::seq_state_e seq_state,
    output alu_ops_pkg::word_t      result,
    output logic                    result_valid
);

    import alu_ops_pkg::*;

    word_t a_q;
    word_t b_q;
    logic  valid_q;
    logic  done_q;
    word_t acc;

    // ------------------------------
    // Stage 1 operand registers
    // ------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= data_valid;
        end
    end

    always_ff @(posedge ap_clk) begin
        a_q    <= op_a;
        b_q    <= op_b;
        done_q <= (seq_state == SEQ_DONE);
    end

    // ------------------------------
    // Stage 2 compute
    // ------------------------------
    always_ff @(posedge ap_clk) begin
        if (valid_q) begin
            case (alu_op)
                ALU_ADD: result <= a_q + b_q;
                ALU_SUB: result <= a_q - b_q;
                // Low word of the product
                ALU_MUL: result <= a_q * b_q;
                ALU_ACC: result <= acc + a_q;
                default: result <= a_q;
            endcase
        end
    end

    // Accumulator restarts on the edge that emits the sum
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            acc          <= '0;
            result_valid <= 1'b0;
        end else begin
            if (valid_q && alu_op == ALU_ACC) begin
                acc <= done_q ? '0 : acc + a_q;
            end
            result_valid <= valid_q && (alu_op != ALU_ACC || done_q);
        end
    end

endmodule : alu_ops_kernel

/* alu_ops/alu_ops_result_stage.sv */
`timescale 1ns/100ps

module alu_ops_result_stage (
    input  logic                    ap_clk,
    input  logic                    areset_generator,
    input  logic                    in_valid,
    input  alu_ops_pkg::route_t     src,
    input  alu_ops_pkg::seq_state_e seq_state,
    input  alu_ops_pkg::seq_id_t    seq_id,
    input  alu_ops_pkg::hops_t      hops,
    input  alu_ops_pkg::word_t      result,
    input  logic                    result_valid,
    input  alu_ops_pkg::route_t     dest,
    output logic                    push,
    output alu_ops_pkg::word_t      out_word,
    output alu_ops_pkg::route_t     out_dest,
    output alu_ops_pkg::route_t     out_src,
    output alu_ops_pkg::seq_state_e out_seq_state,
    output alu_ops_pkg::seq_id_t    out_seq_id,
    output alu_ops_pkg::hops_t      out_hops,
    output logic                    pipe_busy
);

    import alu_ops_pkg::*;

    logic [KERNEL_STAGES-1:0] vld;
    route_t                   src_dl   [KERNEL_STAGES];
    seq_state_e               state_dl [KERNEL_STAGES];
    seq_id_t                  id_dl    [KERNEL_STAGES];
    hops_t                    hops_dl  [KERNEL_STAGES];

    // ------------------------------
    // Metadata delay line
    // ------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            vld <= '0;
        end else begin
            vld <= {vld[KERNEL_STAGES-2:0], in_valid};
        end
    end

    always_ff @(posedge ap_clk) begin
        src_dl[0]   <= src;
        state_dl[0] <= seq_state;
        id_dl[0]    <= seq_id;
        hops_dl[0]  <= hops;
        for (int i = 1; i < KERNEL_STAGES; i++) begin
            src_dl[i]   <= src_dl[i-1];
            state_dl[i] <= state_dl[i-1];
            id_dl[i]    <= id_dl[i-1];
            hops_dl[i]  <= hops_dl[i-1];
        end
    end

    // Tail of the delay line lines up with the kernel result
    assign push          = result_valid;
    assign out_word      = result;
    assign out_dest      = dest;
    assign out_src       = src_dl[KERNEL_STAGES-1];
    assign out_seq_state = state_dl[KERNEL_STAGES-1];
    assign out_seq_id    = id_dl[KERNEL_STAGES-1];
    assign out_hops      = hops_dl[KERNEL_STAGES-1];

    // Includes the packet just read from the input FIFO
    assign pipe_busy = in_valid | (|vld);

    // A kernel result must have its metadata at the tail
    assert property (@(posedge ap_clk) disable iff (areset_generator)
        result_valid |-> vld[KERNEL_STAGES-1])
        else $error("kernel result without matching metadata");

endmodule : alu_ops_result_stage

/* hdl/alu_ops_engine.sv */
`timescale 1ns/100ps

module alu_ops_engine (
    input  logic                    ap_clk,
    input  logic                    areset_generator,
    input  logic                    in_valid,
    input  alu_ops_pkg::word_t      op_a,
    input  alu_ops_pkg::word_t      op_b,
    input  alu_ops_pkg::route_t     src,
    input  alu_ops_pkg::seq_state_e seq_state,
    input  alu_ops_pkg::seq_id_t    seq_id,
    input  alu_ops_pkg::hops_t      hops,
    output logic                    in_full,
    input  logic                    config_start,
    input  logic                    config_valid,
    input  alu_ops_pkg::alu_op_e    config_op,
    input  alu_ops_pkg::route_t     config_dest,
    output logic                    configure_memory_setup,
    input  logic                    out_pop,
    output logic                    out_valid,
    output alu_ops_pkg::word_t      out_result,
    output alu_ops_pkg::route_t     out_dest,
    output alu_ops_pkg::route_t     out_src,
    output alu_ops_pkg::seq_state_e out_seq_state,
    output alu_ops_pkg::seq_id_t    out_seq_id,
    output alu_ops_pkg::hops_t      out_hops,
    output logic                    done_out
);

    import alu_ops_pkg::*;

    // Registered inputs
    logic       in_valid_reg;
    word_t      op_a_reg;
    word_t      op_b_reg;
    route_t     src_reg;
    seq_state_e seq_state_reg;
    seq_id_t    seq_id_reg;
    hops_t      hops_reg;
    logic       config_start_reg;
    logic       config_valid_reg;
    alu_op_e    config_op_reg;
    route_t     config_dest_reg;
    logic       out_pop_reg;

    // Input FIFO side
    logic [IN_PKT_W-1:0] in_dout;
    logic                in_rd_en;
    logic                in_rd_valid;
    logic                in_empty;
    word_t               pop_op_a;
    word_t               pop_op_b;
    route_t              pop_src;
    logic                pop_state_bit;
    seq_id_t             pop_seq_id;
    hops_t               pop_hops;

    // Control and kernel
    logic    run_enable;
    logic    running;
    alu_op_e active_op;
    route_t  active_dest;
    word_t   kernel_result;
    logic    kernel_valid;

    // Output FIFO side
    logic                 push;
    word_t                push_word;
    route_t               push_dest;
    route_t               push_src;
    seq_state_e           push_seq_state;
    seq_id_t              push_seq_id;
    hops_t                push_hops;
    logic                 pipe_busy;
    logic [OUT_PKT_W-1:0] out_dout;
    logic                 out_rd_en;
    logic                 out_full;
    logic                 out_empty;
    logic                 out_prog_full;
    logic                 out_state_bit;

    // ------------------------------
    // Input registers
    // ------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            in_valid_reg     <= 1'b0;
            config_start_reg <= 1'b0;
            config_valid_reg <= 1'b0;
            out_pop_reg      <= 1'b0;
        end else begin
            in_valid_reg     <= in_valid;
            config_start_reg <= config_start;
            config_valid_reg <= config_valid;
            out_pop_reg      <= out_pop;
        end
    end

    always_ff @(posedge ap_clk) begin
        op_a_reg        <= op_a;
        op_b_reg        <= op_b;
        src_reg         <= src;
        seq_state_reg   <= seq_state;
        seq_id_reg      <= seq_id;
        hops_reg        <= hops;
        config_op_reg   <= config_op;
        config_dest_reg <= config_dest;
    end

    // ------------------------------
    // Input FIFO
    // ------------------------------
    // Stop popping once the output FIFO nears full
    assign in_rd_en = ~in_empty & run_enable & ~out_prog_full;

    sync_fifo #(
        .WIDTH (IN_PKT_W),
        .DEPTH (FIFO_DEPTH),
        .THRESH(PROG_THRESH)
    ) inst_fifo_in (
        .ap_clk          (ap_clk),
        .areset_generator(areset_generator),
        .wr_en           (in_valid_reg),
        .din             ({op_a_reg, op_b_reg, src_reg, seq_state_reg, seq_id_reg, hops_reg}),
        .rd_en           (in_rd_en),
        .dout            (in_dout),
        .rd_valid        (in_rd_valid),
        .full            (in_full),
        .empty           (in_empty),
        .prog_full       ()
    );

    assign {pop_op_a, pop_op_b, pop_src, pop_state_bit, pop_seq_id, pop_hops} = in_dout;

    alu_ops_setup_fsm inst_setup_fsm (
        .ap_clk                (ap_clk),
        .areset_generator      (areset_generator),
        .config_start          (config_start_reg),
        .config_valid          (config_valid_reg),
        .config_op             (config_op_reg),
        .config_dest           (config_dest_reg),
        .out_prog_full         (out_prog_full),
        .configure_memory_setup(configure_memory_setup),
        .run_enable            (run_enable),
        .active_op             (active_op),
        .active_dest           (active_dest),
        .running               (running)
    );

    alu_ops_kernel inst_kernel (
        .ap_clk          (ap_clk),
        .areset_generator(areset_generator),
        .alu_op          (active_op),
        .data_valid      (in_rd_valid),
        .op_a            (pop_op_a),
        .op_b            (pop_op_b),
        .seq_state       (seq_state_e'(pop_state_bit)),
        .result          (kernel_result),
        .result_valid    (kernel_valid)
    );

    alu_ops_result_stage inst_result_stage (
        .ap_clk          (ap_clk),
        .areset_generator(areset_generator),
        .in_valid        (in_rd_valid),
        .src             (pop_src),
        .seq_state       (seq_state_e'(pop_state_bit)),
        .seq_id          (pop_seq_id),
        .hops            (pop_hops),
        .result          (kernel_result),
        .result_valid    (kernel_valid),
        .dest            (active_dest),
        .push            (push),
        .out_word        (push_word),
        .out_dest        (push_dest),
        .out_src         (push_src),
        .out_seq_state   (push_seq_state),
        .out_seq_id      (push_seq_id),
        .out_hops        (push_hops),
        .pipe_busy       (pipe_busy)
    );

    // ------------------------------
    // Output FIFO
    // ------------------------------
    assign out_rd_en = out_pop_reg & ~out_empty;

    sync_fifo #(
        .WIDTH (OUT_PKT_W),
        .DEPTH (FIFO_DEPTH),
        .THRESH(PROG_THRESH)
    ) inst_fifo_out (
        .ap_clk          (ap_clk),
        .areset_generator(areset_generator),
        .wr_en           (push),
        .din             ({push_word, push_dest, push_src, push_seq_state, push_seq_id,
                           push_hops}),
        .rd_en           (out_rd_en),
        .dout            (out_dout),
        .rd_valid        (out_valid),
        .full            (out_full),
        .empty           (out_empty),
        .prog_full       (out_prog_full)
    );

    assign {out_result, out_dest, out_src, out_state_bit, out_seq_id, out_hops} = out_dout;
    assign out_seq_state = seq_state_e'(out_state_bit);

    // Drained means nothing queued, in flight or waiting in the input register
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            done_out <= 1'b0;
        end else begin
            done_out <= running & in_empty & out_empty & ~pipe_busy & ~in_valid_reg;
        end
    end

    // Pops stop in time to leave room for packets in flight
    assert property (@(posedge ap_clk) disable iff (areset_generator) push |-> !out_full)
        else $error("output FIFO overflow under back-pressure");

endmodule : alu_ops_engine

/* sim/tb_alu_ops_ref.svh */
`ifndef TB_ALU_OPS_REF_SVH
`define TB_ALU_OPS_REF_SVH

// ------------------------------
// Reference model
// ------------------------------
// acc_sum is the ACC total of the packets before this one
function automatic word_t ref_result(alu_op_e op, word_t a, word_t b, word_t acc_sum);
    logic [63:0] product;
    product = {32'd0, a} * {32'd0, b};
    case (op)
        ALU_ADD: return a + b;
        ALU_SUB: return a - b;
        // Only the low word leaves the engine
        ALU_MUL: return product[31:0];
        ALU_ACC: return acc_sum + a;
        default: return a;
    endcase
endfunction

function automatic word_t xorshift32(word_t x);
    word_t y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
endfunction

// ------------------------------
// Compare tasks
// ------------------------------
task automatic check_word(input string name, input word_t exp, input word_t act);
    if (act !== exp) begin
        $display("ERR %s expected %h actual %h", name, exp, act);
        end_with_failure("data word mismatch");
    end
endtask

task automatic check_route(input string name, input route_t exp, input route_t act);
    if (act !== exp) begin
        $display("ERR %s expected %h actual %h", name, exp, act);
        end_with_failure("route field mismatch");
    end
endtask

task automatic check_seq_state(input string name, input seq_state_e exp,
                               input seq_state_e act);
    if (act !== exp) begin
        $display("ERR %s expected %h actual %h", name, exp, act);
        end_with_failure("sequence state mismatch");
    end
endtask

task automatic check_seq_id(input string name, input seq_id_t exp, input seq_id_t act);
    if (act !== exp) begin
        $display("ERR %s expected %h actual %h", name, exp, act);
        end_with_failure("sequence id mismatch");
    end
endtask

task automatic check_hops(input string name, input hops_t exp, input hops_t act);
    if (act !== exp) begin
        $display("ERR %s expected %h actual %h", name, exp, act);
        end_with_failure("hop count mismatch");
    end
endtask

task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
        $display("ERR %s expected %h actual %h", name, exp, act);
        end_with_failure("control flag mismatch");
    end
endtask

`endif

/* sim/tb_alu_ops_engine.sv */
`timescale 1ns/100ps

module tb_alu_ops_engine;

    import alu_ops_pkg::*;

    localparam int OP_PKTS        = 40;
    localparam int ACC_SEQS       = 6;
    localparam int ACC_MAX_LEN    = 8;
    localparam int BP_PKTS        = 12;
    localparam int BP_HOLD        = 40;
    localparam int DONE_LIMIT     = 10;
    // Reset, setup and drain of one phase
    localparam int PHASE_OVERHEAD = 80;
    localparam int TOTAL_CYCLES   = 4 * (OP_PKTS + PHASE_OVERHEAD)
                                  + (ACC_SEQS * ACC_MAX_LEN + PHASE_OVERHEAD)
                                  + (BP_PKTS + BP_HOLD + PHASE_OVERHEAD);
    localparam int TIMEOUT_CYCLES = 2 * TOTAL_CYCLES;

    typedef struct packed {
        word_t      result;
        route_t     dest;
        route_t     src;
        seq_state_e seq_state;
        seq_id_t    seq_id;
        hops_t      hops;
    } exp_pkt_t;

    logic       ap_clk;
    logic       areset_generator;
    logic       in_valid;
    word_t      op_a;
    word_t      op_b;
    route_t     src;
    seq_state_e seq_state;
    seq_id_t    seq_id;
    hops_t      hops;
    logic       in_full;
    logic       config_start;
    logic       config_valid;
    alu_op_e    config_op;
    route_t     config_dest;
    logic       configure_memory_setup;
    logic       out_pop;
    logic       out_valid;
    word_t      out_result;
    route_t     out_dest;
    route_t     out_src;
    seq_state_e out_seq_state;
    seq_id_t    out_seq_id;
    hops_t      out_hops;
    logic       done_out;

    exp_pkt_t exp_q[$];
    exp_pkt_t head;
    word_t    rng_state;
    int       cycle_count;

    alu_ops_engine dut (.*);

    always #4 ap_clk = ~ap_clk;

    task automatic end_with_failure(input string reason);
        $display("TESTBENCH FAILED");
        $fatal(1, "%s", reason);
    endtask

    `include "tb_alu_ops_ref.svh"

    function automatic word_t next_word();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    always @(posedge ap_clk) begin
        if (cycle_count >= TIMEOUT_CYCLES) begin
            end_with_failure("timeout, the run went past its cycle limit");
        end else begin
            cycle_count <= cycle_count + 1;
        end
    end

    // ------------------------------
    // Output checker
    // ------------------------------
    always @(posedge ap_clk) begin
        if (!areset_generator && out_valid) begin
            if (exp_q.size() == 0) begin
                end_with_failure("output packet arrived with none expected");
            end else begin
                head = exp_q.pop_front();
                check_word("out_result", head.result, out_result);
                check_route("out_dest", head.dest, out_dest);
                check_route("out_src", head.src, out_src);
                check_seq_state("out_seq_state", head.seq_state, out_seq_state);
                check_seq_id("out_seq_id", head.seq_id, out_seq_id);
                check_hops("out_hops", head.hops, out_hops);
            end
        end
    end

    // ------------------------------
    // Stimulus tasks
    // ------------------------------
    task automatic reset_engine();
        areset_generator <= 1'b1;
        in_valid         <= 1'b0;
        config_start     <= 1'b0;
        config_valid     <= 1'b0;
        out_pop          <= 1'b0;
        repeat (2) @(posedge ap_clk);
        areset_generator <= 1'b0;
        @(posedge ap_clk);
        check_flag("configure_memory_setup", 1'b0, configure_memory_setup);
        check_flag("out_valid", 1'b0, out_valid);
        check_flag("done_out", 1'b0, done_out);
        check_flag("in_full", 1'b0, in_full);
    endtask

    task automatic wait_done(input int limit);
        int waited;
        waited = 0;
        while (done_out !== 1'b1 && waited < limit) begin
            @(posedge ap_clk);
            waited++;
        end
        if (done_out !== 1'b1) begin
            end_with_failure("done_out did not rise within the allowed cycles");
        end
    endtask

    // Request pulse comes exactly 3 cycles after config_start
    task automatic configure_engine(input alu_op_e op, input route_t dest);
        config_start <= 1'b1;
        out_pop      <= 1'b1;
        repeat (3) begin
            @(posedge ap_clk);
            check_flag("configure_memory_setup", 1'b0, configure_memory_setup);
        end
        @(posedge ap_clk);
        check_flag("configure_memory_setup", 1'b1, configure_memory_setup);
        config_valid <= 1'b1;
        config_op    <= op;
        config_dest  <= dest;
        @(posedge ap_clk);
        check_flag("configure_memory_setup", 1'b0, configure_memory_setup);
        config_valid <= 1'b0;
        wait_done(DONE_LIMIT);
    endtask

    task automatic queue_expected(input word_t res, input route_t dest, input route_t s,
                                  input seq_state_e st, input seq_id_t id, input hops_t h);
        exp_pkt_t e;
        e.result    = res;
        e.dest      = dest;
        e.src       = s;
        e.seq_state = st;
        e.seq_id    = id;
        e.hops      = h;
        exp_q.push_back(e);
    endtask

    task automatic send_packet(input word_t a, input word_t b, input route_t s,
                               input seq_state_e st, input seq_id_t id, input hops_t h);
        while (in_full) begin
            in_valid <= 1'b0;
            @(posedge ap_clk);
        end
        in_valid  <= 1'b1;
        op_a      <= a;
        op_b      <= b;
        src       <= s;
        seq_state <= st;
        seq_id    <= id;
        hops      <= h;
        @(posedge ap_clk);
    endtask

    task automatic send_random_ops(input alu_op_e op, input route_t dest, input int count);
        word_t a;
        word_t b;
        word_t meta;
        for (int i = 0; i < count; i++) begin
            a    = next_word();
            b    = next_word();
            meta = next_word();
            queue_expected(ref_result(op, a, b, '0), dest, meta[7:0],
                           seq_state_e'(meta[8]), meta[31:16], meta[12:9]);
            send_packet(a, b, meta[7:0], seq_state_e'(meta[8]), meta[31:16], meta[12:9]);
        end
        in_valid <= 1'b0;
    endtask

    task automatic drain_outputs();
        while (exp_q.size() != 0) begin
            @(posedge ap_clk);
        end
        wait_done(DONE_LIMIT);
    endtask

    // ------------------------------
    // Phases
    // ------------------------------
    task automatic run_op_phase(input alu_op_e op);
        route_t dest;
        dest = route_t'(next_word());
        reset_engine();
        configure_engine(op, dest);
        send_random_ops(op, dest, OP_PKTS);
        drain_outputs();
    endtask

    // One result per sequence, carried by the DONE packet
    task automatic run_acc_phase();
        route_t     dest;
        word_t      a;
        word_t      meta;
        word_t      acc_sum;
        seq_id_t    id;
        seq_state_e st;
        int         len;
        dest = route_t'(next_word());
        reset_engine();
        configure_engine(ALU_ACC, dest);
        acc_sum = '0;
        for (int s = 0; s < ACC_SEQS; s++) begin
            meta = next_word();
            len  = 1 + int'(meta[2:0]);
            id   = meta[31:16];
            for (int k = 0; k < len; k++) begin
                a    = next_word();
                meta = next_word();
                st   = (k == len - 1) ? SEQ_DONE : SEQ_RUNNING;
                if (st == SEQ_DONE) begin
                    queue_expected(ref_result(ALU_ACC, a, meta, acc_sum), dest, meta[7:0],
                                   st, id, meta[12:9]);
                    acc_sum = '0;
                end else begin
                    acc_sum = acc_sum + a;
                end
                send_packet(a, meta, meta[7:0], st, id, meta[12:9]);
            end
        end
        in_valid <= 1'b0;
        drain_outputs();
    endtask

    // Output FIFO fills past its threshold and the engine pauses
    task automatic run_backpressure_phase();
        route_t dest;
        dest = route_t'(next_word());
        reset_engine();
        configure_engine(ALU_ADD, dest);
        out_pop <= 1'b0;
        send_random_ops(ALU_ADD, dest, BP_PKTS);
        repeat (BP_HOLD) begin
            @(posedge ap_clk);
            check_flag("out_valid", 1'b0, out_valid);
        end
        out_pop <= 1'b1;
        drain_outputs();
    endtask

    initial begin
        ap_clk           = 1'b0;
        areset_generator = 1'b1;
        in_valid         = 1'b0;
        op_a             = '0;
        op_b             = '0;
        src              = '0;
        seq_state        = SEQ_RUNNING;
        seq_id           = '0;
        hops             = '0;
        config_start     = 1'b0;
        config_valid     = 1'b0;
        config_op        = ALU_NOP;
        config_dest      = '0;
        out_pop          = 1'b0;
        rng_state        = 32'd79;
        cycle_count      = 0;
        @(posedge ap_clk);
        run_op_phase(ALU_NOP);
        run_op_phase(ALU_ADD);
        run_op_phase(ALU_SUB);
        run_op_phase(ALU_MUL);
        run_acc_phase();
        run_backpressure_phase();
        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule : tb_alu_ops_engine

/* sim.f */
+incdir+sim
common/alu_ops_pkg.sv
hdl/sync_fifo.sv
alu_ops/alu_ops_setup_fsm.sv
alu_ops/alu_ops_kernel.sv
alu_ops/alu_ops_result_stage.sv
hdl/alu_ops_engine.sv
sim/tb_alu_ops_engine.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the testbench with Verilator, result taken from sim.log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --timescale 1ns/100ps -f sim.f \
    --top-module tb_alu_ops_engine -o tb_alu_ops_engine \
    && ./obj_dir/tb_alu_ops_engine > sim.log 2>&1 \
    || echo "build or simulation stopped with an error"
cat sim.log 2>/dev/null
grep -q "^TESTBENCH PASSED$" sim.log 2>/dev/null && echo "RESULT: PASS" \
    || { echo "RESULT: FAIL"; exit 1; }
